/* ppi_consts.svh */
`ifndef PPI_CONSTS_SVH
`define PPI_CONSTS_SVH

// width of every port, latch and host data word
`define PPI_DATA_W 8

// selects one of port A, port B, port C or control
`define PPI_ADDR_W 2

// command queue slots, which is also the host's full credit
`define PPI_QUEUE_DEPTH 4

// mode-set word, all four groups input, mode 0
`define PPI_CTRL_RESET 8'h9B

`endif

/* ppiBusPkg.sv */
`include "ppi_consts.svh"

package ppiBusPkg;

  // register map seen by the host
  typedef enum logic [`PPI_ADDR_W-1:0] {
    regPortA = 2'd0,
    regPortB = 2'd1,
    regPortC = 2'd2,
    regCtrl  = 2'd3
  } regAddrT;

  // one host access after sampling
  // read clear means a write of data to addr
  typedef struct packed {
    logic                   read;
    regAddrT                addr;
    logic [`PPI_DATA_W-1:0] data;
  } hostCmdT;

endpackage

/* ppiCtrlPkg.sv */
package ppiCtrlPkg;

  // mode-set view, used when setFlag is 1
  // a direction bit of 1 makes that group an input
  typedef struct packed {
    logic       setFlag;
    logic [1:0] grpAMode;
    logic       dirA;
    logic       dirCUpper;
    logic       grpBMode;
    logic       dirB;
    logic       dirCLower;
  } modeWordT;

  // bit set/reset view, used when setFlag is 0
  typedef struct packed {
    logic       setFlag;
    logic [2:0] unused;
    logic [2:0] bitSel;
    logic       bitVal;
  } bsrWordT;

  // same control byte, two decodings selected by bit 7
  typedef union packed {
    modeWordT mode;
    bsrWordT  bsr;
  } ctrlWordT;

endpackage

/* ppiCmdIf.sv */
// command link with credit return
// valid and cmd go downstream, credit pulses come back up
interface ppiCmdIf;

  logic               valid;
  ppiBusPkg::hostCmdT cmd;
  logic               credit;

  modport sender (
    output valid,
    output cmd,
    input  credit
  );

  modport receiver (
    input  valid,
    input  cmd,
    output credit
  );

endinterface

/* ppiHostPort.sv */
`include "ppi_consts.svh"

module ppiHostPort (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     csN,
  input  logic                     wrN,
  input  logic                     rdN,
  input  ppiBusPkg::regAddrT       addr,
  input  logic [`PPI_DATA_W-1:0]   wrData,
  output logic                     busy,
  ppiCmdIf.sender                  link
);

  localparam int CreditW = $clog2(`PPI_QUEUE_DEPTH + 1);

  logic [CreditW-1:0]     credits;
  logic                   access;
  logic                   take;
  logic                   accepted;
  logic                   sampRead;
  ppiBusPkg::regAddrT     sampAddr;
  logic [`PPI_DATA_W-1:0] sampData;

  // wrN wins when both strobes are low
  assign access = ~csN & (~wrN | ~rdN);

  // out of credits means every queue slot is spoken for
  assign busy = (credits == '0);
  assign take = access & ~busy;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      credits    <= CreditW'(`PPI_QUEUE_DEPTH);
      accepted   <= 1'b0;
      link.valid <= 1'b0;
    end else begin
      accepted   <= take;
      link.valid <= accepted;
      // credit is spent when the access is accepted
      case ({take, link.credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // first stage holds the raw bus fields
  always_ff @(posedge clk) begin
    if (take) begin
      sampRead <= wrN;
      sampAddr <= addr;
      sampData <= wrData;
    end
  end

  // second stage builds the command sent to the queue
  always_ff @(posedge clk) begin
    if (accepted) begin
      link.cmd.read <= sampRead;
      link.cmd.addr <= sampAddr;
      link.cmd.data <= sampData;
    end
  end

endmodule

/* ppiCmdQueue.sv */
`include "ppi_consts.svh"

module ppiCmdQueue (
  input  logic       clk,
  input  logic       rstN,
  ppiCmdIf.receiver  inLink,
  ppiCmdIf.sender    outLink
);

  localparam int Depth = `PPI_QUEUE_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  localparam int CntW  = $clog2(Depth + 1);

  ppiBusPkg::hostCmdT mem [Depth];
  logic [PtrW-1:0]    wrPtr;
  logic [PtrW-1:0]    rdPtr;
  logic [CntW-1:0]    count;
  logic               push;
  logic               pop;

  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // host never sends without a credit, so push never overflows
  assign push = inLink.valid;
  assign pop  = outLink.credit;

  assign outLink.valid = (count != '0);
  assign outLink.cmd   = mem[rdPtr];

  // a slot frees exactly when the core takes the head
  assign inLink.credit = pop;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inLink.cmd;
    end
  end

endmodule

/* ppiPortCore.sv */
`include "ppi_consts.svh"

module ppiPortCore (
  input  logic                   clk,
  input  logic                   rstN,
  ppiCmdIf.receiver              link,
  input  logic [`PPI_DATA_W-1:0] portAIn,
  input  logic [`PPI_DATA_W-1:0] portBIn,
  input  logic [`PPI_DATA_W-1:0] portCIn,
  output logic [`PPI_DATA_W-1:0] portAOut,
  output logic [`PPI_DATA_W-1:0] portBOut,
  output logic [`PPI_DATA_W-1:0] portCOut,
  output logic                   portAOe,
  output logic                   portBOe,
  output logic [`PPI_DATA_W-1:0] portCOe,
  output logic [`PPI_DATA_W-1:0] rdData,
  output logic                   rdValid
);

  ppiCtrlPkg::ctrlWordT   ctrlReg;
  ppiCtrlPkg::ctrlWordT   cmdWord;
  logic [`PPI_DATA_W-1:0] latchA;
  logic [`PPI_DATA_W-1:0] latchB;
  logic [`PPI_DATA_W-1:0] latchC;
  logic [`PPI_DATA_W-1:0] maskA;
  logic [`PPI_DATA_W-1:0] maskB;
  logic [`PPI_DATA_W-1:0] rdSel;
  logic                   rdPending;
  logic                   takeWrite;
  logic                   startRead;

  assign cmdWord = link.cmd.data;

  // only mode 0 is acted on, so direction bits alone set the enables
  assign portAOe = ~ctrlReg.mode.dirA;
  assign portBOe = ~ctrlReg.mode.dirB;
  assign portCOe = {{4{~ctrlReg.mode.dirCUpper}}, {4{~ctrlReg.mode.dirCLower}}};

  assign portAOut = latchA;
  assign portBOut = latchB;
  assign portCOut = latchC;

  assign maskA = {`PPI_DATA_W{portAOe}};
  assign maskB = {`PPI_DATA_W{portBOe}};

  // head stays in the queue until the second read cycle
  assign takeWrite   = link.valid & ~link.cmd.read & ~rdPending;
  assign startRead   = link.valid & link.cmd.read & ~rdPending;
  assign link.credit = takeWrite | rdPending;

  // output bits read back from the latch, input bits from the pins
  always_comb begin
    case (link.cmd.addr)
      ppiBusPkg::regPortA: rdSel = (portAIn & ~maskA) | (latchA & maskA);
      ppiBusPkg::regPortB: rdSel = (portBIn & ~maskB) | (latchB & maskB);
      ppiBusPkg::regPortC: rdSel = (portCIn & ~portCOe) | (latchC & portCOe);
      default:             rdSel = ctrlReg;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlReg   <= `PPI_CTRL_RESET;
      latchA    <= '0;
      latchB    <= '0;
      latchC    <= '0;
      rdPending <= 1'b0;
      rdValid   <= 1'b0;
    end else begin
      rdPending <= startRead;
      rdValid   <= rdPending;
      if (takeWrite) begin
        case (link.cmd.addr)
          ppiBusPkg::regPortA: latchA <= link.cmd.data;
          ppiBusPkg::regPortB: latchB <= link.cmd.data;
          ppiBusPkg::regPortC: latchC <= link.cmd.data;
          default: begin
            if (cmdWord.mode.setFlag) begin
              // new mode resets every output latch
              ctrlReg <= cmdWord;
              latchA  <= '0;
              latchB  <= '0;
              latchC  <= '0;
            end else begin
              latchC[cmdWord.bsr.bitSel] <= cmdWord.bsr.bitVal;
            end
          end
        endcase
      end
    end
  end

  // sampled on the first read edge, held through rdValid
  always_ff @(posedge clk) begin
    if (startRead) begin
      rdData <= rdSel;
    end
  end

endmodule

/* ppiTop.sv */
`include "ppi_consts.svh"

module ppiTop (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   csN,
  input  logic                   wrN,
  input  logic                   rdN,
  input  logic [`PPI_ADDR_W-1:0] addr,
  input  logic [`PPI_DATA_W-1:0] wrData,
  output logic [`PPI_DATA_W-1:0] rdData,
  output logic                   rdValid,
  output logic                   busy,
  input  logic [`PPI_DATA_W-1:0] portAIn,
  input  logic [`PPI_DATA_W-1:0] portBIn,
  input  logic [`PPI_DATA_W-1:0] portCIn,
  output logic [`PPI_DATA_W-1:0] portAOut,
  output logic [`PPI_DATA_W-1:0] portBOut,
  output logic [`PPI_DATA_W-1:0] portCOut,
  output logic                   portAOe,
  output logic                   portBOe,
  output logic [`PPI_DATA_W-1:0] portCOe
);

  // host port to queue, then queue to core
  ppiCmdIf hostLink ();
  ppiCmdIf coreLink ();

  ppiHostPort host0 (
    .clk    (clk),
    .rstN   (rstN),
    .csN    (csN),
    .wrN    (wrN),
    .rdN    (rdN),
    .addr   (ppiBusPkg::regAddrT'(addr)),
    .wrData (wrData),
    .busy   (busy),
    .link   (hostLink.sender)
  );

  ppiCmdQueue queue0 (
    .clk     (clk),
    .rstN    (rstN),
    .inLink  (hostLink.receiver),
    .outLink (coreLink.sender)
  );

  ppiPortCore core0 (
    .clk      (clk),
    .rstN     (rstN),
    .link     (coreLink.receiver),
    .portAIn  (portAIn),
    .portBIn  (portBIn),
    .portCIn  (portCIn),
    .portAOut (portAOut),
    .portBOut (portBOut),
    .portCOut (portCOut),
    .portAOe  (portAOe),
    .portBOe  (portBOe),
    .portCOe  (portCOe),
    .rdData   (rdData),
    .rdValid  (rdValid)
  );

endmodule

/* ppiTb.sv */
`include "ppi_consts.svh"

module ppiTb;

  logic                   clk;
  logic                   rstN;
  logic                   csN;
  logic                   wrN;
  logic                   rdN;
  logic                   rdValid;
  logic                   busy;
  logic                   portAOe;
  logic                   portBOe;
  logic [`PPI_ADDR_W-1:0] addr;
  logic [`PPI_DATA_W-1:0] wrData;
  logic [`PPI_DATA_W-1:0] rdData;
  logic [`PPI_DATA_W-1:0] portAIn;
  logic [`PPI_DATA_W-1:0] portBIn;
  logic [`PPI_DATA_W-1:0] portCIn;
  logic [`PPI_DATA_W-1:0] portAOut;
  logic [`PPI_DATA_W-1:0] portBOut;
  logic [`PPI_DATA_W-1:0] portCOut;
  logic [`PPI_DATA_W-1:0] portCOe;

  // expected state, built from the register rules
  logic [7:0] expCtrl;
  logic [7:0] expA;
  logic [7:0] expB;
  logic [7:0] expC;
  logic [7:0] expData [0:255];
  int         expCount = 0;
  int         rdIdx = 0;
  int         errors = 0;
  int         lastErrors = 0;
  int         testNum = 0;
  logic       checkPorts = 1'b0;
  logic       sawBusy = 1'b0;
  integer     seed = 32'hb9e6_8405;

  // port writes accepted with no read ahead of them, aged one stage per edge
  logic [3:0] wrAge = '0;
  logic [1:0] wrAddrAge [0:3];
  logic [7:0] wrDataAge [0:3];
  string      portNames [0:2] = '{"portAOut", "portBOut", "portCOut"};

  ppiTop dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rdValid) begin
      rdIdx <= rdIdx + 1;
    end
  end

  always @(posedge clk) begin
    wrAge <= {wrAge[2:0], !csN && !wrN && !busy && addr != 2'd3 && expCount == rdIdx};
    wrAddrAge[0] <= addr;
    wrDataAge[0] <= wrData;
    for (int i = 1; i < 4; i++) begin
      wrAddrAge[i] <= wrAddrAge[i-1];
      wrDataAge[i] <= wrDataAge[i-1];
    end
  end

  // direction bit 1 means input, so enables are the inverted bits
  function automatic logic [9:0] oeExpect(input logic [7:0] ctrl);
    return {~ctrl[4], ~ctrl[1], {4{~ctrl[3]}}, {4{~ctrl[0]}}};
  endfunction

  function automatic logic [7:0] readExpect(input logic [1:0] a);
    logic [9:0] oe;
    oe = oeExpect(expCtrl);
    case (a)
      2'd0:    return (portAIn & ~{8{oe[9]}}) | (expA & {8{oe[9]}});
      2'd1:    return (portBIn & ~{8{oe[8]}}) | (expB & {8{oe[8]}});
      2'd2:    return (portCIn & ~oe[7:0]) | (expC & oe[7:0]);
      default: return expCtrl;
    endcase
  endfunction

  function automatic logic [7:0] pickPort(input logic [1:0] a, input logic [7:0] pa,
                                          input logic [7:0] pb, input logic [7:0] pc);
    case (a)
      2'd0:    return pa;
      2'd1:    return pb;
      default: return pc;
    endcase
  endfunction

  assert property (@(posedge clk) disable iff (!rstN) rdValid |-> rdIdx < expCount)
    else begin
      errors = errors + 1;
      $display("rdValid pulsed with no read outstanding");
    end
  assert property (@(posedge clk) disable iff (!rstN) rdValid |-> rdData == expData[rdIdx])
    else begin
      errors = errors + 1;
      $display("** Error: rdData = %h, expected %h", $sampled(rdData),
               expData[$sampled(rdIdx)]);
    end
  assert property (@(posedge clk) disable iff (!rstN) rdValid |=> !rdValid)
    else begin
      errors = errors + 1;
      $display("rdValid stayed high for two cycles");
    end
  assert property (@(posedge clk) disable iff (!rstN)
      busy |-> (expCount - rdIdx) >= `PPI_QUEUE_DEPTH)
    else begin
      errors = errors + 1;
      $display("busy rose with free queue slots");
    end
  assert property (@(posedge clk) disable iff (!rstN) checkPorts |-> !busy && !rdValid)
    else begin
      errors = errors + 1;
      $display("busy or rdValid high while idle");
    end
  // a port write shows on the pins right after the third edge that follows it
  assert property (@(posedge clk) disable iff (!rstN)
      wrAge[3] |-> pickPort(wrAddrAge[3], portAOut, portBOut, portCOut) == wrDataAge[3])
    else begin
      errors = errors + 1;
      $display("** Error: %s = %h, expected %h", portNames[$sampled(wrAddrAge[3])],
               pickPort($sampled(wrAddrAge[3]), $sampled(portAOut), $sampled(portBOut),
                        $sampled(portCOut)),
               $sampled(wrDataAge[3]));
    end
  assert property (@(posedge clk) disable iff (!rstN) checkPorts |-> portAOut == expA)
    else begin
      errors = errors + 1;
      $display("** Error: portAOut = %h, expected %h", $sampled(portAOut), expA);
    end
  assert property (@(posedge clk) disable iff (!rstN) checkPorts |-> portBOut == expB)
    else begin
      errors = errors + 1;
      $display("** Error: portBOut = %h, expected %h", $sampled(portBOut), expB);
    end
  assert property (@(posedge clk) disable iff (!rstN) checkPorts |-> portCOut == expC)
    else begin
      errors = errors + 1;
      $display("** Error: portCOut = %h, expected %h", $sampled(portCOut), expC);
    end
  assert property (@(posedge clk) disable iff (!rstN)
      checkPorts |-> {portAOe, portBOe, portCOe} == oeExpect(expCtrl))
    else begin
      errors = errors + 1;
      $display("** Error: {portAOe, portBOe, portCOe} = %h, expected %h",
               $sampled({portAOe, portBOe, portCOe}), oeExpect(expCtrl));
    end

  task automatic giveUp(input string what);
    $display("timeout: %s", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic applyWrite(input logic [1:0] a, input logic [7:0] d);
    case (a)
      2'd0: expA = d;
      2'd1: expB = d;
      2'd2: expC = d;
      default: begin
        if (d[7]) begin
          expCtrl = d;
          expA = 8'h00;
          expB = 8'h00;
          expC = 8'h00;
        end else begin
          expC[d[3:1]] = d[0];
        end
      end
    endcase
  endtask

  // holds the access until an edge samples it with busy low
  task automatic issue(input logic read, input logic [1:0] a, input logic [7:0] d);
    int waited;
    waited = 0;
    checkPorts <= 1'b0;
    csN <= 1'b0;
    wrN <= read;
    rdN <= ~read;
    addr <= a;
    wrData <= d;
    forever begin
      @(posedge clk);
      if (!busy) break;
      sawBusy = 1'b1;
      waited++;
      if (waited > 50) giveUp("busy never dropped");
    end
    if (read) begin
      expData[expCount] = readExpect(a);
      expCount++;
    end else begin
      applyWrite(a, d);
    end
  endtask

  // control readback, then wait until every read has come back
  task automatic drain;
    int waited;
    waited = 0;
    issue(1'b1, 2'd3, 8'h00);
    csN <= 1'b1;
    wrN <= 1'b1;
    rdN <= 1'b1;
    forever begin
      @(posedge clk);
      if (rdIdx == expCount) break;
      waited++;
      if (waited > 200) giveUp("reads did not complete");
    end
    checkPorts <= 1'b1;
    repeat (2) @(posedge clk);
  endtask

  task automatic setPins;
    portAIn <= 8'($random(seed));
    portBIn <= 8'($random(seed));
    portCIn <= 8'($random(seed));
  endtask

  task automatic endTest(input string name);
    testNum++;
    $display("test %0d %s: %0d errors", testNum, name, errors - lastErrors);
    lastErrors = errors;
  endtask

  initial begin
    rstN = 1'b0;
    csN = 1'b1;
    wrN = 1'b1;
    rdN = 1'b1;
    addr = '0;
    wrData = '0;
    portAIn = '0;
    portBIn = '0;
    portCIn = '0;
    expCtrl = `PPI_CTRL_RESET;
    expA = 8'h00;
    expB = 8'h00;
    expC = 8'h00;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    checkPorts <= 1'b1;
    repeat (2) @(posedge clk);
    drain();
    endTest("reset state");

    // all outputs, mode 0
    issue(1'b0, 2'd3, 8'h80);
    issue(1'b0, 2'd0, 8'hA5);
    issue(1'b0, 2'd1, 8'h3C);
    issue(1'b0, 2'd2, 8'hE1);
    drain();
    endTest("all outputs");

    // A in, B out, upper C in, lower C out
    issue(1'b0, 2'd3, 8'h98);
    issue(1'b0, 2'd0, 8'h5A);
    issue(1'b0, 2'd1, 8'hC3);
    issue(1'b0, 2'd2, 8'h96);
    for (int round = 0; round < 4; round++) begin
      setPins();
      for (int a = 0; a < 4; a++) issue(1'b1, 2'(a), 8'h00);
      drain();
    end
    endTest("mixed directions");

    // toggle every port C bit through BSR words
    for (int i = 0; i < 8; i++) begin
      issue(1'b0, 2'd3, {4'b0000, 3'(i), ~expC[i]});
      drain();
    end
    endTest("bit set reset");

    setPins();
    sawBusy = 1'b0;
    for (int i = 0; i < 12; i++) issue(1'b1, 2'(i % 4), 8'h00);
    drain();
    assert (sawBusy)
      else begin
        errors = errors + 1;
        $display("busy never rose during the read burst");
      end
    endTest("read burst");

    issue(1'b0, 2'd3, 8'h80);
    issue(1'b0, 2'd0, 8'h11);
    issue(1'b0, 2'd1, 8'h22);
    issue(1'b0, 2'd2, 8'h33);
    drain();
    issue(1'b0, 2'd3, 8'h80);
    issue(1'b1, 2'd1, 8'h00);
    drain();
    endTest("mode set clears latches");

    $display("tests %0d, errors %0d", testNum, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* ppi.f */
+incdir+.
ppiBusPkg.sv
ppiCtrlPkg.sv
ppiCmdIf.sv
ppiHostPort.sv
ppiCmdQueue.sv
ppiPortCore.sv
ppiTop.sv
ppiTb.sv

/* run.sh */
#!/bin/sh
# build and run the PPI testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f ppi.f --top-module ppiTb -o ppiSim
./obj_dir/ppiSim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log
echo "simulation passed"
